// File: rtl/dump_pkg.sv
// Debug dump shared types and protocol constants

package dump_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------

    // Register file or memory word
    typedef logic [31:0] dump_word_t;

    // Memory byte address
    typedef logic [31:0] dump_addr_t;

    // One byte on the transmitter
    typedef logic [7:0]  tx_byte_t;

    // Register file index
    typedef logic [4:0]  rf_idx_t;

    // ----------------------------------------
    // Protocol constants
    // ----------------------------------------

    // Opens every dump
    localparam tx_byte_t    ALERT_CODE = 8'hDA;
    // Words in the register section
    localparam int unsigned RF_WORDS   = 32;
    // Byte step between memory words
    localparam dump_addr_t  MEM_STEP   = 32'd4;

endpackage

// File: rtl/dump_word_if.sv
// Four-phase word handoff between the dump sequencer and the byte serializer

`timescale 1ns/1ps

interface dump_word_if;
    import dump_pkg::*;

    // Request held until ack rises
    logic       req;
    // Word held stable while req is high
    dump_word_t word;
    // Only the low byte goes out
    logic       single;
    // High after the last byte is done, low once req falls
    logic       ack;

    // Sequencer side
    modport source (
        output req, word, single,
        input  ack
    );

    // Serializer side
    modport sink (
        input  req, word, single,
        output ack
    );

endinterface

// File: rtl/dump_sequencer.sv
// Dump section FSM that selects each word, drives read addresses and requests words

`timescale 1ns/1ps

module dump_sequencer (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // Trigger and completion
    input  logic                 dump_trigger_i,
    output logic                 dump_done_o,

    // Combinational register file debug read
    output dump_pkg::rf_idx_t    rf_dbg_addr_o,
    input  dump_pkg::dump_word_t rf_dbg_data_i,

    // Combinational data memory read and dump range
    output dump_pkg::dump_addr_t dmem_addr_o,
    input  dump_pkg::dump_word_t dmem_data_i,
    input  dump_pkg::dump_addr_t min_addr_i,
    input  dump_pkg::dump_addr_t max_addr_i,
    output logic                 dump_needs_mem_o,

    // Word handoff to the serializer
    dump_word_if.source          word_src
);
    import dump_pkg::*;

    // ----------------------------------------
    // Section state
    // ----------------------------------------
    typedef enum logic [2:0] {
        S_IDLE,
        S_ALERT,
        S_REGS,
        S_MIN_ADDR,
        S_MAX_ADDR,
        S_PAYLOAD,
        S_DONE
    } seq_state_t;

    seq_state_t state_q;
    seq_state_t sec_next;

    logic       req_q;
    logic       done_q;
    rf_idx_t    rf_idx_q;
    dump_addr_t mem_addr_q;

    // Current word fully handed off
    logic       word_ack;

    assign word_ack = req_q & word_src.ack;

    // ----------------------------------------
    // Word source select
    // ----------------------------------------
    always_comb begin
        case (state_q)
            S_ALERT:    word_src.word = dump_word_t'(ALERT_CODE);
            S_REGS:     word_src.word = rf_dbg_data_i;
            S_MIN_ADDR: word_src.word = min_addr_i;
            S_MAX_ADDR: word_src.word = max_addr_i;
            S_PAYLOAD:  word_src.word = dmem_data_i;
            default:    word_src.word = '0;
        endcase
    end

    // Alert is the only one-byte word
    assign word_src.single = (state_q == S_ALERT);
    assign word_src.req    = req_q;

    // Section after the current word completes
    always_comb begin
        sec_next = state_q;
        case (state_q)
            S_ALERT:    sec_next = S_REGS;
            S_REGS: begin
                if (rf_idx_q == rf_idx_t'(RF_WORDS - 1)) begin
                    sec_next = S_MIN_ADDR;
                end
            end
            S_MIN_ADDR: sec_next = S_MAX_ADDR;
            S_MAX_ADDR: sec_next = S_PAYLOAD;
            // Stop once the word just sent sat at or above max
            S_PAYLOAD: begin
                if (mem_addr_q >= max_addr_i) begin
                    sec_next = S_DONE;
                end
            end
            default:    sec_next = state_q;
        endcase
    end

    // ----------------------------------------
    // Sequencing registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= S_IDLE;
            req_q      <= 1'b0;
            done_q     <= 1'b0;
            rf_idx_q   <= '0;
            mem_addr_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (dump_trigger_i) begin
                        state_q  <= S_ALERT;
                        rf_idx_q <= '0;
                    end
                end
                S_DONE: begin
                    // Flag only after the last ack has dropped
                    if (!done_q && !word_src.ack) begin
                        done_q <= 1'b1;
                    end else if (done_q && !dump_trigger_i) begin
                        done_q  <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    // New request only once the previous ack is gone
                    if (!req_q && !word_src.ack) begin
                        req_q <= 1'b1;
                    end else if (word_ack) begin
                        req_q   <= 1'b0;
                        state_q <= sec_next;
                        if (state_q == S_REGS) begin
                            rf_idx_q <= rf_idx_q + 1'b1;
                        end
                        // Payload walk starts at the range minimum
                        if (state_q == S_MAX_ADDR) begin
                            mem_addr_q <= min_addr_i;
                        end
                        if (state_q == S_PAYLOAD && sec_next == S_PAYLOAD) begin
                            mem_addr_q <= mem_addr_q + MEM_STEP;
                        end
                    end
                end
            endcase
        end
    end

    // Read addresses held until the word is captured
    assign rf_dbg_addr_o    = rf_idx_q;
    assign dmem_addr_o      = mem_addr_q;

    // Memory owned across range and payload words
    assign dump_needs_mem_o = (state_q == S_MIN_ADDR) || (state_q == S_MAX_ADDR) ||
                              (state_q == S_PAYLOAD);
    assign dump_done_o      = done_q;

endmodule

// File: rtl/word_serializer.sv
// Byte serializer that sends a handed-off word LSB first over the start/done transmitter

`timescale 1ns/1ps

module word_serializer (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Word handoff from the sequencer
    dump_word_if.sink          word_snk,

    // Byte transmitter
    output dump_pkg::tx_byte_t tx_data_o,
    output logic               tx_start_o,
    input  logic               tx_done_i
);
    import dump_pkg::*;

    // ----------------------------------------
    // Serializer state
    // ----------------------------------------
    typedef enum logic [1:0] {
        S_WAIT_REQ,
        S_SEND,
        S_WAIT_DONE,
        S_ACK
    } ser_state_t;

    // Byte position within the word
    typedef logic [1:0] byte_idx_t;

    ser_state_t state_q;
    byte_idx_t  byte_idx_q;

    // Captured payload
    dump_word_t word_q;
    logic       single_q;

    // Last byte of this word in flight
    logic       last_byte;

    assign last_byte = single_q | (&byte_idx_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= S_WAIT_REQ;
            byte_idx_q <= '0;
        end else begin
            case (state_q)
                // Ack is low here, so a high req is a fresh request
                S_WAIT_REQ: begin
                    if (word_snk.req) begin
                        byte_idx_q <= '0;
                        state_q    <= S_SEND;
                    end
                end
                // One-cycle start pulse
                S_SEND: state_q <= S_WAIT_DONE;
                S_WAIT_DONE: begin
                    if (tx_done_i) begin
                        if (last_byte) begin
                            state_q <= S_ACK;
                        end else begin
                            byte_idx_q <= byte_idx_q + 1'b1;
                            state_q    <= S_SEND;
                        end
                    end
                end
                // Release ack once req falls
                S_ACK: begin
                    if (!word_snk.req) begin
                        state_q <= S_WAIT_REQ;
                    end
                end
                default: state_q <= S_WAIT_REQ;
            endcase
        end
    end

    // Payload capture on the request edge
    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT_REQ && word_snk.req) begin
            word_q   <= word_snk.word;
            single_q <= word_snk.single;
        end
    end

    // Little-endian byte pick
    assign tx_data_o    = word_q[{byte_idx_q, 3'b000} +: 8];
    assign tx_start_o   = (state_q == S_SEND);
    assign word_snk.ack = (state_q == S_ACK);

endmodule

// File: rtl/dump_unit.sv
// Debug state dump unit that streams alert, registers, range and memory words

`timescale 1ns/1ps

module dump_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // Trigger and completion
    input  logic                 dump_trigger_i,
    output logic                 dump_done_o,

    // Byte transmitter
    output dump_pkg::tx_byte_t   tx_data_o,
    output logic                 tx_start_o,
    input  logic                 tx_done_i,

    // Register file debug read
    output dump_pkg::rf_idx_t    rf_dbg_addr_o,
    input  dump_pkg::dump_word_t rf_dbg_data_i,

    // Data memory read and dump range
    output logic                 dump_needs_mem_o,
    output dump_pkg::dump_addr_t dmem_addr_o,
    input  dump_pkg::dump_word_t dmem_data_i,
    input  dump_pkg::dump_addr_t min_addr_i,
    input  dump_pkg::dump_addr_t max_addr_i
);

    // ----------------------------------------
    // Word handoff
    // ----------------------------------------
    dump_word_if u_word_if ();

    // Section FSM and read address control
    dump_sequencer u_sequencer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dump_trigger_i   (dump_trigger_i),
        .dump_done_o      (dump_done_o),
        .rf_dbg_addr_o    (rf_dbg_addr_o),
        .rf_dbg_data_i    (rf_dbg_data_i),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_data_i      (dmem_data_i),
        .min_addr_i       (min_addr_i),
        .max_addr_i       (max_addr_i),
        .dump_needs_mem_o (dump_needs_mem_o),
        .word_src         (u_word_if)
    );

    // Word to byte stream
    word_serializer u_serializer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .word_snk   (u_word_if),
        .tx_data_o  (tx_data_o),
        .tx_start_o (tx_start_o),
        .tx_done_i  (tx_done_i)
    );

endmodule

// File: tests/dump_unit_props.sv
// Handshake assertions for the dump unit transmitter and done flag

`timescale 1ns/1ps

module dump_unit_props (
    input logic clk_i,
    input logic rst_ni,
    input logic dump_trigger_i,
    input logic dump_done_i,
    input logic tx_start_i,
    input logic tx_done_i,
    input logic dump_needs_mem_i
);

    // Byte started and not yet answered
    logic byte_in_flight;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            byte_in_flight <= 1'b0;
        end else if (tx_start_i) begin
            byte_in_flight <= 1'b1;
        end else if (tx_done_i) begin
            byte_in_flight <= 1'b0;
        end
    end

    // ----------------------------------------
    // Transmitter handshake
    // ----------------------------------------
    start_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tx_start_i |=> !tx_start_i)
        else $error("tx_start_o held high for two cycles");

    start_wait_done_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        byte_in_flight |-> !tx_start_i)
        else $error("tx_start_o pulsed before the previous byte was done");

    done_no_start_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(dump_done_i && tx_start_i))
        else $error("tx_start_o high while dump_done_o is set");

    // Trigger low with done low means the unit is idle
    idle_no_mem_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!dump_trigger_i && !dump_done_i) |-> !dump_needs_mem_i)
        else $error("dump_needs_mem_o high while idle");

endmodule

bind dump_unit dump_unit_props u_props (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dump_trigger_i   (dump_trigger_i),
    .dump_done_i      (dump_done_o),
    .tx_start_i       (tx_start_o),
    .tx_done_i        (tx_done_i),
    .dump_needs_mem_i (dump_needs_mem_o)
);

// File: tests/dump_monitor.sv
// Dump stream checker that rebuilds the expected bytes and compares each transmitted byte

`timescale 1ns/1ps

module dump_monitor (
    input logic               clk_i,
    input logic               rst_ni,
    input logic               dump_trigger_i,
    input logic               dump_done_i,
    input logic               dump_needs_mem_i,
    input logic               tx_start_i,
    input dump_pkg::tx_byte_t tx_data_i
);
    import dump_pkg::*;

    // Expected byte and memory flag per position
    tx_byte_t    exp_bytes [$];
    logic        exp_mem [$];
    string       test_name  = "none";
    logic        active     = 1'b0;
    int unsigned byte_cnt   = 0;
    int unsigned test_errs  = 0;
    int unsigned stray_errs = 0;
    logic        done_prev  = 1'b0;
    logic        trig_prev  = 1'b0;

    // Little-endian bytes of one word
    function automatic void push_word(dump_word_t w, int n, logic mem);
        for (int i = 0; i < n; i++) begin
            exp_bytes.push_back(w[8*i +: 8]);
            exp_mem.push_back(mem);
        end
    endfunction

    function automatic void start_test(string name, dump_addr_t lo, dump_addr_t hi,
                                       dump_word_t base, dump_word_t step, dump_word_t pat);
        dump_addr_t addr;
        exp_bytes.delete();
        exp_mem.delete();
        test_name = name;
        test_errs = 0;
        byte_cnt  = 0;
        push_word({24'h0, ALERT_CODE}, 1, 1'b0);
        for (int n = 0; n < 32; n++) begin
            push_word(base + step * n, 4, 1'b0);
        end
        push_word(lo, 4, 1'b1);
        push_word(hi, 4, 1'b1);
        // Stop after the first word at or above the maximum
        addr = lo;
        push_word(addr ^ pat, 4, 1'b1);
        while (addr < hi) begin
            addr = addr + MEM_STEP;
            push_word(addr ^ pat, 4, 1'b1);
        end
        active = 1'b1;
    endfunction

    function automatic int unsigned finish_test();
        if (exp_bytes.size() != 0) begin
            $display("%s: dump ended with %0d bytes missing", test_name, exp_bytes.size());
            test_errs++;
        end
        active = 1'b0;
        return test_errs;
    endfunction

    // ----------------------------------------
    // Byte and flag checks
    // ----------------------------------------
    always @(posedge clk_i) begin
        tx_byte_t exp_b;
        logic     exp_m;
        if (rst_ni && tx_start_i) begin
            if (!active) begin
                $display("Byte %02h was sent while no dump was running", tx_data_i);
                stray_errs++;
            end else if (exp_bytes.size() == 0) begin
                $display("%s: extra byte %02h after the end of the dump", test_name, tx_data_i);
                test_errs++;
            end else begin
                exp_b = exp_bytes.pop_front();
                exp_m = exp_mem.pop_front();
                if (tx_data_i !== exp_b) begin
                    $display("Error: %s byte %0d expected %02h actual %02h",
                             test_name, byte_cnt, exp_b, tx_data_i);
                    test_errs++;
                end
                if (dump_needs_mem_i !== exp_m) begin
                    $display("%s: memory request flag was %b at byte %0d but should be %b",
                             test_name, dump_needs_mem_i, byte_cnt, exp_m);
                    test_errs++;
                end
                byte_cnt++;
            end
        end
        if (rst_ni && active) begin
            if (dump_done_i && !done_prev && exp_bytes.size() != 0) begin
                $display("%s: dump done rose with %0d bytes still to send",
                         test_name, exp_bytes.size());
                test_errs++;
            end
            if (dump_done_i && dump_needs_mem_i) begin
                $display("%s: memory request flag still high after dump done", test_name);
                test_errs++;
            end
            if (done_prev && trig_prev && !dump_done_i) begin
                $display("%s: dump done fell while the trigger was still high", test_name);
                test_errs++;
            end
            if (done_prev && !trig_prev && dump_done_i) begin
                $display("%s: dump done stayed high after the trigger dropped", test_name);
                test_errs++;
            end
        end
        done_prev <= dump_done_i;
        trig_prev <= dump_trigger_i;
    end

endmodule

// File: tests/tb_dump_unit.sv
// Testbench for the debug dump unit with table-driven dumps and bus models

`timescale 1ns/1ps

module tb_dump_unit;
    import dump_pkg::*;

    localparam int unsigned CLK_PERIOD = 4;
    localparam int unsigned N_TESTS    = 5;
    // Register n holds base + n * RF_STEP
    localparam dump_word_t  RF_STEP    = 32'h0103_0507;

    // ----------------------------------------
    // Test table
    // ----------------------------------------
    string      test_name [N_TESTS] = '{"small_range", "single_word", "min_above_max",
                                        "unaligned_max", "long_range"};
    dump_addr_t test_min  [N_TESTS] = '{32'h0000_0100, 32'h0000_0200, 32'h0000_0400,
                                        32'h0000_0040, 32'h0000_1000};
    dump_addr_t test_max  [N_TESTS] = '{32'h0000_010C, 32'h0000_0200, 32'h0000_0300,
                                        32'h0000_0052, 32'h0000_1040};
    dump_word_t test_base [N_TESTS] = '{32'h1000_0000, 32'hA5A5_0001, 32'h0000_0000,
                                        32'hFFFF_FFF0, 32'h1234_5678};
    dump_word_t test_pat  [N_TESTS] = '{32'hC0DE_0000, 32'h5A5A_5A5A, 32'hFFFF_FFFF,
                                        32'h0F0F_F0F0, 32'h8000_0001};

    logic       clk_i;
    logic       rst_ni;
    logic       dump_trigger_i;
    logic       dump_done_o;
    tx_byte_t   tx_data_o;
    logic       tx_start_o;
    logic       tx_done_i;
    rf_idx_t    rf_dbg_addr_o;
    dump_word_t rf_dbg_data_i;
    logic       dump_needs_mem_o;
    dump_addr_t dmem_addr_o;
    dump_word_t dmem_data_i;
    dump_addr_t min_addr_i;
    dump_addr_t max_addr_i;

    // Register file and memory models
    dump_word_t rf_model [RF_WORDS];
    dump_word_t mem_pat;
    integer     seed = 32'h2e82_511b;

    assign rf_dbg_data_i = rf_model[rf_dbg_addr_o];
    assign dmem_data_i   = dmem_addr_o ^ mem_pat;

    dump_unit u_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dump_trigger_i   (dump_trigger_i),
        .dump_done_o      (dump_done_o),
        .tx_data_o        (tx_data_o),
        .tx_start_o       (tx_start_o),
        .tx_done_i        (tx_done_i),
        .rf_dbg_addr_o    (rf_dbg_addr_o),
        .rf_dbg_data_i    (rf_dbg_data_i),
        .dump_needs_mem_o (dump_needs_mem_o),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_data_i      (dmem_data_i),
        .min_addr_i       (min_addr_i),
        .max_addr_i       (max_addr_i)
    );

    dump_monitor u_mon (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dump_trigger_i   (dump_trigger_i),
        .dump_done_i      (dump_done_o),
        .dump_needs_mem_i (dump_needs_mem_o),
        .tx_start_i       (tx_start_o),
        .tx_data_i        (tx_data_o)
    );

    // Bytes in one dump across alert, registers, range and payload
    function automatic int unsigned dump_bytes(dump_addr_t lo, dump_addr_t hi);
        int unsigned span;
        span = (lo >= hi) ? 0 : (hi - lo);
        return 1 + 4 * RF_WORDS + 8 + 4 * ((span + MEM_STEP - 1) / MEM_STEP + 1);
    endfunction

    // Range inputs and model contents for one row
    task automatic load_row(int t);
        min_addr_i = test_min[t];
        max_addr_i = test_max[t];
        mem_pat    = test_pat[t];
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = test_base[t] + RF_STEP * i;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Transmitter answers each start with a one-cycle done
    initial begin
        int tx_delay;
        tx_done_i = 1'b0;
        forever begin
            @(posedge clk_i);
            if (tx_start_o) begin
                tx_delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (tx_delay) @(negedge clk_i);
                tx_done_i = 1'b1;
                @(negedge clk_i);
                tx_done_i = 1'b0;
            end
        end
    end

    // Watchdog sized from the byte count of every row
    initial begin
        int unsigned budget_ns;
        budget_ns = (16 + 200 * N_TESTS) * CLK_PERIOD;
        for (int t = 0; t < N_TESTS; t++) begin
            budget_ns += dump_bytes(test_min[t], test_max[t]) * 8 * CLK_PERIOD;
        end
        #(budget_ns);
        $display("Timeout: dump did not finish within %0d ns", budget_ns);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    // Stimulus loop
    // ----------------------------------------
    initial begin
        int unsigned pass_cnt;
        int unsigned fail_cnt;
        int unsigned errs;
        int          hold;
        pass_cnt       = 0;
        fail_cnt       = 0;
        rst_ni         = 1'b0;
        dump_trigger_i = 1'b0;
        min_addr_i     = '0;
        max_addr_i     = '0;
        mem_pat        = '0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            repeat (2) @(negedge clk_i);
            load_row(t);
            u_mon.start_test(test_name[t], test_min[t], test_max[t], test_base[t],
                             RF_STEP, test_pat[t]);
            dump_trigger_i = 1'b1;
            do @(negedge clk_i); while (!dump_done_o);
            // Done must stay up while the trigger is held
            hold = 1 + ($unsigned($random(seed)) % 8);
            repeat (hold) @(negedge clk_i);
            dump_trigger_i = 1'b0;
            do @(negedge clk_i); while (dump_done_o);
            errs = u_mon.finish_test();
            if (errs == 0) begin
                pass_cnt++;
                $display("Test %s: PASS", test_name[t]);
            end else begin
                fail_cnt++;
                $display("Test %s: FAIL with %0d errors", test_name[t], errs);
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && u_mon.stray_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/dump_pkg.sv
rtl/dump_word_if.sv
rtl/dump_sequencer.sv
rtl/word_serializer.sv
rtl/dump_unit.sv
tests/dump_unit_props.sv
tests/dump_monitor.sv
tests/tb_dump_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the dump unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dump_unit -f filelist.f \
    -o sim_tb_dump_unit || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_tb_dump_unit 2>&1)
echo "$out"

echo "$out" | grep -q "^Simulation completed successfully$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
